// ==== cpuTop.f ====
src/isaPkg.sv
src/ctrlPkg.sv
src/alu.sv
src/registerFile.sv
src/controlUnit.sv
src/datapath.sv
src/cpuTop.sv
verification/cpuTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the cpuTb testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module cpuTb -f cpuTop.f -o VcpuTb

if ! ./obj_dir/VcpuTb > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error status"
    exit 1
fi
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
if ! grep -q "Test passed" sim.log; then
    echo "simulation ended without a verdict"
    exit 1
fi

// ==== verification/programGolden.txt ====
# P addr word loads memory, W addr data is the next expected write, N count is the write total.
# all numbers are hex; a # starts a comment that runs to the end of the line.
P 0000 4105  # adi r1, r0, 5
P 0001 43FD  # adi r3, r0, -3
P 0002 8160  # swd r1, 60(r0)
P 0003 F780  # add r2, r1, r3
P 0004 8261
P 0005 FD81  # sub r2, r3, r1
P 0006 8262
P 0007 F782  # and r2, r1, r3
P 0008 8263
P 0009 F783  # orr r2, r1, r3
P 000A 8264
P 000B F484  # not r2, r1
P 000C 8265
P 000D FC85  # tcp r2, r3
P 000E 8266
P 000F FC86  # shl r2, r3
P 0010 8267
P 0011 FC87  # shr r2, r3
P 0012 8268
P 0013 62A5  # lhi r2, a5
P 0014 5A3C  # ori r2, r2, 3c
P 0015 8269
P 0016 0701  # bne r1, r3 taken
P 0017 8170
P 0018 8171
P 0019 0501  # bne r1, r1 not taken
P 001A 8172
P 001B 8173
P 001C 1501  # beq r1, r1 taken
P 001D 8174
P 001E 8175
P 001F 1701  # beq r1, r3 not taken
P 0020 8176
P 0021 8177
P 0022 2401  # bgz r1 taken
P 0023 8178
P 0024 8179
P 0025 2C01  # bgz r3 not taken
P 0026 817A
P 0027 817B
P 0028 3C01  # blz r3 taken
P 0029 817C
P 002A 817D
P 002B 3001  # blz r0 not taken
P 002C 817E
P 002D 817F
P 002E 9030  # jmp 030
P 002F 8150
P 0030 A038  # jal 038
P 0031 433C  # adi r3, r0, 3c
P 0032 FC1A  # jrl r3
P 0033 9040  # jmp 040
P 0038 8250  # swd r2, 50(r0)
P 0039 F819  # jpr r2
P 003C 8251  # swd r2, 51(r0)
P 003D F819  # jpr r2
P 0040 7158  # lwd r1, 58(r0)
P 0041 8152
P 0042 7361  # lwd r3, 61(r0), reads an earlier store
P 0043 8353
P 0044 F01D  # hlt
P 0058 BEEF
W 0060 0005
W 0061 0002
W 0062 FFF8
W 0063 0005
W 0064 FFFD
W 0065 FFFA
W 0066 0003
W 0067 FFFA
W 0068 FFFE
W 0069 A53C
W 0071 0005
W 0072 0005
W 0073 0005
W 0075 0005
W 0076 0005
W 0077 0005
W 0079 0005
W 007A 0005
W 007B 0005
W 007D 0005
W 007E 0005
W 007F 0005
W 0050 0031
W 0051 0033
W 0052 BEEF
W 0053 0002
N 1A

// ==== verification/cpuTb.sv ====
`timescale 1ns/1ns

module cpuTb import isaPkg::*; ();

    localparam int FetchLimit  = 10;   // cycles from reset release to the first fetch.
    localparam int HaltLimit   = 5000;
    localparam int QuietCycles = 50;

    logic  clk = 1'b0;
    logic  rst;
    logic  readM;
    logic  writeM;
    word_t address;
    word_t writeData;
    word_t readData;
    logic  inputReady;
    logic  ackOutput;
    logic  halted;

    word_t mem [256];
    word_t expAddr [$];
    word_t expData [$];
    int    expectedCount;
    int    writeCount;
    int    errorCount;
    int    timeoutCount;

    logic        busy;
    logic        reqIsWrite;
    word_t       reqAddr;
    word_t       reqData;
    logic [1:0]  waitLeft;
    logic [31:0] rngState;

    always #4 clk = ~clk;

    cpuTop #(
        .ResetPc (16'h0000)
    ) u_dut (
        .clk        (clk),
        .rst        (rst),
        .readM      (readM),
        .writeM     (writeM),
        .address    (address),
        .writeData  (writeData),
        .readData   (readData),
        .inputReady (inputReady),
        .ackOutput  (ackOutput),
        .halted     (halted)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic checkValue(input string name, input word_t expected, input word_t actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
            errorCount++;
        end
    endtask

    // lines start with P, W, N or #, and a # runs to the end of its line.
    task automatic loadGolden();
        int         fd;
        int         ch;
        int         code;
        logic [7:0] tag;
        word_t      a;
        word_t      d;
        fd = $fopen("verification/programGolden.txt", "r");
        assert (fd != 0) else begin
            $display("could not open verification/programGolden.txt");
            errorCount++;
            return;
        end
        ch = $fgetc(fd);
        while (ch >= 0) begin
            tag  = ch[7:0];
            code = 2;
            case (tag)
                "#": begin
                    while (ch >= 0 && ch != 10) begin
                        ch = $fgetc(fd);
                    end
                end
                "P": begin
                    code = $fscanf(fd, "%h %h", a, d);
                    mem[a[7:0]] = d;
                end
                "W": begin
                    code = $fscanf(fd, "%h %h", a, d);
                    expAddr.push_back(a);
                    expData.push_back(d);
                end
                "N": begin
                    code = $fscanf(fd, "%h", expectedCount) + 1;
                end
                default: begin
                    if (!(tag inside {" ", "\t", "\r", "\n"})) begin
                        code = 0;
                    end
                end
            endcase
            assert (code == 2) else begin
                $display("golden file has a malformed line starting with '%c'", tag);
                errorCount++;
            end
            ch = $fgetc(fd);
        end
        $fclose(fd);
        checkValue("golden write list length", word_t'(expectedCount), word_t'(expAddr.size()));
    endtask

    task automatic recordWrite(input word_t a, input word_t d);
        assert (writeCount < expAddr.size()) else begin
            $display("write %0d of %h to %h goes past the expected list", writeCount, d, a);
            errorCount++;
        end
        if (writeCount < expAddr.size()) begin
            checkValue($sformatf("address of write %0d", writeCount), expAddr[writeCount], a);
            checkValue($sformatf("writeData of write %0d", writeCount), expData[writeCount], d);
        end
        mem[a[7:0]] = d;
        writeCount++;
    endtask

    // memory answers each request after zero to three wait states.
    always begin
        @(posedge clk);
        #1;
        inputReady = 1'b0;
        ackOutput  = 1'b0;
        readData   = '0;
        if (rst) begin
            busy = 1'b0;
        end else if (readM || writeM) begin
            assert (!(readM && writeM)) else begin
                $display("read and write requested together at %0t", $time);
                errorCount++;
            end
            if (!busy) begin
                busy       = 1'b1;
                reqIsWrite = writeM;
                reqAddr    = address;
                reqData    = writeData;
                rngState   = xorshift(rngState);
                waitLeft   = rngState[1:0];
            end else begin
                checkValue("writeM while held", word_t'(reqIsWrite), word_t'(writeM));
                checkValue("address while held", reqAddr, address);
                if (reqIsWrite) begin
                    checkValue("writeData while held", reqData, writeData);
                end
            end
            if (waitLeft != 2'd0) begin
                waitLeft = waitLeft - 2'd1;
            end else if (reqIsWrite) begin
                busy      = 1'b0;
                ackOutput = 1'b1;
                recordWrite(address, writeData);
            end else begin
                busy       = 1'b0;
                inputReady = 1'b1;
                readData   = mem[address[7:0]];
            end
        end else begin
            assert (!busy) else begin
                $display("request at %h was dropped before it was answered", reqAddr);
                errorCount++;
            end
            busy = 1'b0;
        end
    end

    initial begin
        int cycles;
        rst           = 1'b1;
        readData      = '0;
        inputReady    = 1'b0;
        ackOutput     = 1'b0;
        busy          = 1'b0;
        rngState      = 32'hd8cd_53ca;
        writeCount    = 0;
        errorCount    = 0;
        timeoutCount  = 0;
        expectedCount = 0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8'(i) ^ 8'h5a, 8'(i)};
        end
        loadGolden();

        repeat (3) begin
            @(posedge clk);
            #1;
            checkValue("readM in reset", '0, word_t'(readM));
            checkValue("writeM in reset", '0, word_t'(writeM));
            checkValue("halted in reset", '0, word_t'(halted));
        end
        rst = 1'b0;

        cycles = 0;
        while (!readM && cycles < FetchLimit) begin
            checkValue("writeM before first fetch", '0, word_t'(writeM));
            checkValue("halted before first fetch", '0, word_t'(halted));
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!readM) begin
            $display("timeout: no fetch request within %0d cycles of reset release", FetchLimit);
            timeoutCount++;
        end
        checkValue("writes before first fetch", '0, word_t'(writeCount));

        cycles = 0;
        while (!halted && cycles < HaltLimit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!halted) begin
            $display("timeout: the processor did not halt within %0d cycles", HaltLimit);
            timeoutCount++;
        end else begin
            repeat (QuietCycles) begin
                @(posedge clk);
                #1;
                checkValue("readM after halt", '0, word_t'(readM));
                checkValue("writeM after halt", '0, word_t'(writeM));
                checkValue("halted after halt", 16'd1, word_t'(halted));
            end
        end
        checkValue("write count", word_t'(expectedCount), word_t'(writeCount));

        $display("errors: %0d failed checks, %0d timeouts", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== src/cpuTop.sv ====
`timescale 1ns/1ns

module cpuTop import isaPkg::*, ctrlPkg::*; #(
    parameter word_t ResetPc = '0
) (
    input  logic  clk,
    input  logic  rst,
    output logic  readM,
    output logic  writeM,
    output word_t address,
    output word_t writeData,
    input  word_t readData,
    input  logic  inputReady,
    input  logic  ackOutput,
    output logic  halted
);

    opcode_t opcode;
    func_t   func;
    logic    branchTaken;
    logic    irLoad;
    logic    pcWrite;
    logic    regWrite;
    logic    regDst;
    logic    memAddrSel;
    aSrc_t   aSrc;
    bSrc_t   bSrc;
    aluOp_t  aluOp;
    wbSrc_t  wbSrc;
    pcSrc_t  pcSrc;

    controlUnit uControl (
        .clk         (clk),
        .rst         (rst),
        .opcode      (opcode),
        .func        (func),
        .branchTaken (branchTaken),
        .inputReady  (inputReady),
        .ackOutput   (ackOutput),
        .readM       (readM),
        .writeM      (writeM),
        .halted      (halted),
        .irLoad      (irLoad),
        .pcWrite     (pcWrite),
        .regWrite    (regWrite),
        .regDst      (regDst),
        .memAddrSel  (memAddrSel),
        .aSrc        (aSrc),
        .bSrc        (bSrc),
        .aluOp       (aluOp),
        .wbSrc       (wbSrc),
        .pcSrc       (pcSrc)
    );

    datapath #(
        .ResetPc (ResetPc)
    ) uDatapath (
        .clk         (clk),
        .rst         (rst),
        .irLoad      (irLoad),
        .pcWrite     (pcWrite),
        .pcSrc       (pcSrc),
        .aSrc        (aSrc),
        .bSrc        (bSrc),
        .aluOp       (aluOp),
        .regWrite    (regWrite),
        .regDst      (regDst),
        .wbSrc       (wbSrc),
        .memAddrSel  (memAddrSel),
        .readData    (readData),
        .address     (address),
        .writeData   (writeData),
        .opcode      (opcode),
        .func        (func),
        .branchTaken (branchTaken)
    );

endmodule

// ==== src/datapath.sv ====
`timescale 1ns/1ns

module datapath import isaPkg::*, ctrlPkg::*; #(
    parameter word_t ResetPc = '0
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    irLoad,
    input  logic    pcWrite,
    input  pcSrc_t  pcSrc,
    input  aSrc_t   aSrc,
    input  bSrc_t   bSrc,
    input  aluOp_t  aluOp,
    input  logic    regWrite,
    input  logic    regDst,
    input  wbSrc_t  wbSrc,
    input  logic    memAddrSel,
    input  word_t   readData,
    output word_t   address,
    output word_t   writeData,
    output opcode_t opcode,
    output func_t   func,
    output logic    branchTaken
);

    word_t   pc;
    word_t   pcNext;
    word_t   ir;
    word_t   mdr;
    regIdx_t rs;
    regIdx_t rt;
    regIdx_t rd;
    regIdx_t writeReg;
    imm_t    imm;
    target_t target;
    word_t   immSext;
    word_t   immZext;
    word_t   regA;
    word_t   regB;
    word_t   aluA;
    word_t   aluB;
    word_t   aluResult;
    word_t   wbData;
    word_t   branchTarget;
    word_t   jumpTarget;

    assign opcode = ir[15:12];
    assign rs     = ir[11:10];
    assign rt     = ir[9:8];
    assign rd     = ir[7:6];
    assign func   = ir[5:0];
    assign imm    = ir[7:0];
    assign target = ir[11:0];

    assign immSext = {{8{imm[7]}}, imm};
    assign immZext = {8'h00, imm};

    // pc already holds PC+1 once the fetch has completed.
    assign branchTarget = pc + immSext;
    assign jumpTarget   = {pc[15:12], target};

    always_comb begin
        case (pcSrc)
            pcFromInc:    pcNext = aluResult;
            pcFromBranch: pcNext = branchTarget;
            pcFromJump:   pcNext = jumpTarget;
            pcFromReg:    pcNext = regA;
            default:      pcNext = aluResult;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= ResetPc;
            ir <= '0;
        end else begin
            if (irLoad) begin
                ir <= readData;
            end
            if (pcWrite) begin
                pc <= pcNext;
            end
        end
    end

    // readData is only valid on the inputReady edge, the last one with memAddrSel high.
    always_ff @(posedge clk) begin
        if (memAddrSel) begin
            mdr <= readData;
        end
    end

    assign aluA = (aSrc == aFromPc) ? pc : regA;

    always_comb begin
        case (bSrc)
            bFromReg:  aluB = regB;
            bFromSext: aluB = immSext;
            bFromZext: aluB = immZext;
            bFromOne:  aluB = 16'd1;
            default:   aluB = regB;
        endcase
    end

    always_comb begin
        case (wbSrc)
            wbFromAlu:     wbData = aluResult;
            wbFromMem:     wbData = mdr;
            wbFromPcPlus1: wbData = pc;
            default:       wbData = aluResult;
        endcase
    end

    assign writeReg = (wbSrc == wbFromPcPlus1) ? linkReg : (regDst ? rd : rt);

    always_comb begin
        case (opcode)
            opBne:   branchTaken = regA != regB;
            opBeq:   branchTaken = regA == regB;
            opBgz:   branchTaken = $signed(regA) > 0;
            opBlz:   branchTaken = $signed(regA) < 0;
            default: branchTaken = 1'b0;
        endcase
    end

    assign address   = memAddrSel ? aluResult : pc;
    assign writeData = regB;   // SWD stores rt.

    registerFile uRegs (
        .clk         (clk),
        .rst         (rst),
        .readAddr1   (rs),
        .readAddr2   (rt),
        .writeAddr   (writeReg),
        .writeData   (wbData),
        .writeEnable (regWrite),
        .readData1   (regA),
        .readData2   (regB)
    );

    alu uAlu (
        .a      (aluA),
        .b      (aluB),
        .op     (aluOp),
        .result (aluResult)
    );

endmodule

// ==== src/controlUnit.sv ====
`timescale 1ns/1ns

module controlUnit import isaPkg::*, ctrlPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  opcode_t  opcode,
    input  func_t    func,
    input  logic     branchTaken,
    input  logic     inputReady,
    input  logic     ackOutput,
    output logic     readM,
    output logic     writeM,
    output logic     halted,
    output logic     irLoad,
    output logic     pcWrite,
    output logic     regWrite,
    output logic     regDst,
    output logic     memAddrSel,
    output aSrc_t    aSrc,
    output bSrc_t    bSrc,
    output aluOp_t   aluOp,
    output wbSrc_t   wbSrc,
    output pcSrc_t   pcSrc
);

    cpuState_t state;
    cpuState_t nextState;
    logic      started;
    logic      isRtype;
    logic      isBranch;
    logic      isHlt;
    logic      isJpr;
    logic      isJrl;
    logic      isLink;
    logic      writesReg;
    bSrc_t     opBSrc;
    aluOp_t    opAluOp;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= FETCH;
            started <= 1'b0;   // keeps the bus quiet for the first cycle.
        end else begin
            state   <= nextState;
            started <= 1'b1;
        end
    end

    assign isRtype   = opcode == opRtype;
    assign isBranch  = opcode inside {opBne, opBeq, opBgz, opBlz};
    assign isHlt     = isRtype && func == fnHlt;
    assign isJpr     = isRtype && func == fnJpr;
    assign isJrl     = isRtype && func == fnJrl;
    assign isLink    = opcode == opJal || isJrl;
    assign writesReg = isLink || opcode inside {opAdi, opOri, opLhi}
                       || (isRtype && func <= fnShr);

    always_comb begin
        opBSrc  = bFromReg;
        opAluOp = PASSB;
        case (opcode)
            opAdi, opLwd, opSwd: begin
                opBSrc  = bFromSext;
                opAluOp = ADD;   // also the load and store address.
            end
            opOri: begin
                opBSrc  = bFromZext;
                opAluOp = OR;
            end
            opLhi: begin
                opBSrc  = bFromZext;
                opAluOp = LHI;
            end
            opRtype: begin
                case (func)
                    fnAdd: opAluOp = ADD;
                    fnSub: opAluOp = SUB;
                    fnAnd: opAluOp = AND;
                    fnOrr: opAluOp = OR;
                    fnNot: opAluOp = NOT;
                    fnTcp: opAluOp = TCP;
                    fnShl: opAluOp = SHL;
                    fnShr: opAluOp = SHR;
                    default: opAluOp = PASSB;
                endcase
            end
            default: begin
                opAluOp = PASSB;
            end
        endcase
    end

    always_comb begin
        nextState  = state;
        readM      = 1'b0;
        writeM     = 1'b0;
        irLoad     = 1'b0;
        pcWrite    = 1'b0;
        regWrite   = 1'b0;
        regDst     = 1'b0;
        memAddrSel = 1'b0;
        aSrc       = aFromReg;
        bSrc       = opBSrc;
        aluOp      = opAluOp;
        wbSrc      = wbFromAlu;
        pcSrc      = pcFromInc;
        halted     = state == HALT;
        case (state)
            FETCH: begin
                readM   = started;
                aSrc    = aFromPc;   // the ALU forms PC+1 while the fetch waits.
                bSrc    = bFromOne;
                aluOp   = ADD;
                irLoad  = started && inputReady;
                pcWrite = started && inputReady;
                if (started && inputReady) begin
                    nextState = EXECUTE;
                end
            end
            EXECUTE: begin
                if (isBranch) begin
                    pcWrite = branchTaken;
                    pcSrc   = pcFromBranch;
                end else if (opcode == opJmp) begin
                    pcWrite = 1'b1;
                    pcSrc   = pcFromJump;
                end else if (isJpr) begin
                    pcWrite = 1'b1;
                    pcSrc   = pcFromReg;
                end
                if (isHlt) begin
                    nextState = HALT;
                end else if (opcode == opLwd) begin
                    nextState = MEMREAD;
                end else if (opcode == opSwd) begin
                    nextState = MEMWRITE;
                end else if (writesReg) begin
                    nextState = WRITEBACK;
                end else begin
                    nextState = FETCH;
                end
            end
            MEMREAD: begin
                readM      = 1'b1;
                memAddrSel = 1'b1;
                if (inputReady) begin
                    nextState = WRITEBACK;
                end
            end
            MEMWRITE: begin
                writeM     = 1'b1;
                memAddrSel = 1'b1;
                if (ackOutput) begin
                    nextState = FETCH;
                end
            end
            WRITEBACK: begin
                regWrite  = 1'b1;
                regDst    = isRtype;
                pcWrite   = isLink;   // links jump here so the old PC+1 is written first.
                nextState = FETCH;
                if (isJrl) begin
                    pcSrc = pcFromReg;
                end else begin
                    pcSrc = pcFromJump;
                end
                if (opcode == opLwd) begin
                    wbSrc = wbFromMem;
                end else if (isLink) begin
                    wbSrc = wbFromPcPlus1;
                end
            end
            HALT: begin
                nextState = HALT;
            end
            default: begin
                nextState = FETCH;
            end
        endcase
    end

    noOverlap: assert property (
        @(posedge clk) disable iff (rst) !(readM && writeM)
    ) else $error("read and write requested together");

    readHeld: assert property (
        @(posedge clk) disable iff (rst) readM && !inputReady |=> readM
    ) else $error("read request dropped before inputReady");

    writeHeld: assert property (
        @(posedge clk) disable iff (rst) writeM && !ackOutput |=> writeM
    ) else $error("write request dropped before ackOutput");

endmodule

// ==== src/registerFile.sv ====
`timescale 1ns/1ns

module registerFile import isaPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  regIdx_t readAddr1,
    input  regIdx_t readAddr2,
    input  regIdx_t writeAddr,
    input  word_t   writeData,
    input  logic    writeEnable,
    output word_t   readData1,
    output word_t   readData2
);

    word_t regs [4];

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (writeEnable) begin
            regs[writeAddr] <= writeData;
        end
    end

    // a write in the same cycle is seen only after the edge.
    assign readData1 = regs[readAddr1];
    assign readData2 = regs[readAddr2];

    // an X reaching a register points at a bad mux select or an unanswered load.
    writeDataKnown: assert property (
        @(posedge clk) disable iff (rst)
        writeEnable |-> !$isunknown(writeData)
    ) else $error("register write of unknown data to r%0d", writeAddr);

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ns

module alu import isaPkg::*, ctrlPkg::*; (
    input  word_t  a,
    input  word_t  b,
    input  aluOp_t op,
    output word_t  result
);

    always_comb begin
        case (op)
            ADD: begin
                result = a + b;
            end
            SUB: begin
                result = a - b;
            end
            AND: begin
                result = a & b;
            end
            OR: begin
                result = a | b;
            end
            NOT: begin
                result = ~a;
            end
            TCP: begin
                result = ~a + 16'd1;   // two's complement negate.
            end
            SHL: begin
                result = {a[14:0], 1'b0};
            end
            SHR: begin
                result = {a[15], a[15:1]};   // arithmetic shift that keeps the sign bit.
            end
            LHI: begin
                result = {b[7:0], 8'h00};
            end
            PASSB: begin
                result = b;
            end
            default: begin
                result = b;
            end
        endcase
    end

endmodule

// ==== src/ctrlPkg.sv ====
package ctrlPkg;

    typedef enum logic [2:0] {
        FETCH,
        EXECUTE,
        MEMREAD,
        MEMWRITE,
        WRITEBACK,
        HALT
    } cpuState_t;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        NOT,
        TCP,
        SHL,
        SHR,
        LHI,
        PASSB
    } aluOp_t;

    typedef enum logic {aFromReg, aFromPc} aSrc_t;

    typedef enum logic [1:0] {bFromReg, bFromSext, bFromZext, bFromOne} bSrc_t;

    typedef enum logic [1:0] {wbFromAlu, wbFromMem, wbFromPcPlus1} wbSrc_t;

    // pcFromInc takes the ALU sum computed during fetch.
    typedef enum logic [1:0] {pcFromInc, pcFromBranch, pcFromJump, pcFromReg} pcSrc_t;

endpackage

// ==== src/isaPkg.sv ====
package isaPkg;

    typedef logic [15:0] word_t;   // data, address and instruction word.
    typedef logic [1:0]  regIdx_t;
    typedef logic [3:0]  opcode_t;
    typedef logic [5:0]  func_t;
    typedef logic [7:0]  imm_t;
    typedef logic [11:0] target_t;

    localparam opcode_t opBne    = 4'd0;
    localparam opcode_t opBeq    = 4'd1;
    localparam opcode_t opBgz    = 4'd2;
    localparam opcode_t opBlz    = 4'd3;
    localparam opcode_t opAdi    = 4'd4;
    localparam opcode_t opOri    = 4'd5;
    localparam opcode_t opLhi    = 4'd6;
    localparam opcode_t opLwd    = 4'd7;
    localparam opcode_t opSwd    = 4'd8;
    localparam opcode_t opJmp    = 4'd9;
    localparam opcode_t opJal    = 4'd10;
    localparam opcode_t opRtype  = 4'd15;   // function field selects the operation.

    localparam func_t fnAdd = 6'd0;
    localparam func_t fnSub = 6'd1;
    localparam func_t fnAnd = 6'd2;
    localparam func_t fnOrr = 6'd3;
    localparam func_t fnNot = 6'd4;
    localparam func_t fnTcp = 6'd5;
    localparam func_t fnShl = 6'd6;
    localparam func_t fnShr = 6'd7;
    localparam func_t fnJpr = 6'd25;
    localparam func_t fnJrl = 6'd26;
    localparam func_t fnHlt = 6'd29;

    // JAL and JRL leave the return address here.
    localparam regIdx_t linkReg = 2'd2;

endpackage
